//--- vlog.f
hw/uart_cfg_pkg.sv
hw/uart_bus_pkg.sv
hw/uart_chan_if.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_top.sv
verif/uart_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module uart_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator compile step returned an error"
    exit 1
fi

out=$(./obj_dir/Vuart_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- verif/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
    import uart_bus_pkg::*;

    localparam int clks_per_bit = 16;
    localparam int period_ns    = 10;
    localparam int num_frames   = 7;  // tx and rx frames over all tests
    localparam int ack_limit    = 12 * clks_per_bit;
    localparam int frame_limit  = 4 * clks_per_bit;
    localparam int watchdog_ns  = (num_frames * 12 * clks_per_bit + 400) * period_ns;

    logic     clock, reset;
    logic     wb_cyc, wb_stb, wb_we, wb_ack;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w, wb_dat_r;
    wb_sel_t  wb_sel;
    logic     rx, tx;

    logic [31:0] seed = 32'haa3b_c8d0;
    int          cycle;
    int          checks, mismatches, failures;

    uart_top #(.clks_per_bit(clks_per_bit)) dut (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rx       (rx),
        .tx       (tx)
    );

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;  // stable at negedge

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic uart_byte_t rand_byte();
        seed = xorshift(seed);
        return seed[7:0];
    endfunction

    function automatic uart_status_t make_status(input logic frame_error, input logic rx_overrun,
                                                 input logic rx_valid, input logic tx_busy);
        uart_status_t s;
        s.frame_error = frame_error;
        s.rx_overrun  = rx_overrun;
        s.rx_valid    = rx_valid;
        s.tx_busy     = tx_busy;
        return s;
    endfunction

    // ************************************************************************
    // compare tasks
    // ************************************************************************
    task automatic check_byte(input uart_byte_t exp, input uart_byte_t act, input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s, expected 0x%02h got 0x%02h", $time, what, exp, act);
        end
    endtask

    task automatic check_status(input uart_status_t exp, input uart_status_t act,
                                input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s, expected %04b got %04b", $time, what,
                     4'(exp), 4'(act));
        end
    endtask

    task automatic check_word(input wb_data_t exp, input wb_data_t act, input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s, expected 0x%08h got 0x%08h", $time, what, exp, act);
        end
    endtask

    task automatic check_line(input logic exp, input logic act, input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s, expected %b got %b", $time, what, exp, act);
        end
    endtask

    // ************************************************************************
    // bus master, serial driver and serial monitor
    // ************************************************************************
    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                              output wb_data_t rdata, output int ack_cycle);
        int n;
        n = 0;
        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        wb_sel   <= 4'b0001;
        do begin
            @(negedge clock);
            n++;
        end while (wb_ack !== 1'b1 && n < ack_limit);
        if (wb_ack !== 1'b1) begin
            failures++;
            $display("no ack from address %0d within %0d cycles", adr, ack_limit);
        end
        rdata     = wb_dat_r;
        ack_cycle = cycle;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input wb_addr_t adr, output wb_data_t rdata);
        int unused_cycle;
        bus_access(1'b0, adr, '0, rdata, unused_cycle);
    endtask

    task automatic read_status(output uart_status_t st);
        wb_data_t w;
        bus_read(reg_status, w);
        st = uart_status_t'(w[3:0]);
    endtask

    task automatic send_rx_frame(input uart_byte_t data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        @(posedge clock);
        for (int i = 0; i < 10; i++) begin
            rx <= bits[i];  // start bit first, then lsb first
            repeat (clks_per_bit) @(posedge clock);
        end
        rx <= 1'b1;  // one idle bit
        repeat (clks_per_bit) @(posedge clock);
    endtask

    // samples early, middle and late in every bit at negedges
    task automatic watch_tx_frame(output uart_byte_t data, output logic stop,
                                  output int start_cycle);
        logic [9:0] mid;
        logic       early, late;
        int         n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (tx !== 1'b0 && n < frame_limit);
        start_cycle = cycle;
        data        = '0;
        stop        = 1'b0;
        if (tx !== 1'b0) begin
            failures++;
            $display("no frame started on tx within %0d cycles", frame_limit);
            return;
        end
        for (int i = 0; i < 10; i++) begin
            for (int j = 0; j < clks_per_bit; j++) begin
                if (i != 0 || j != 0) @(negedge clock);
                if (j == 1) early = tx;
                if (j == clks_per_bit / 2) mid[i] = tx;
                if (j == clks_per_bit - 1) late = tx;
            end
            check_line(mid[i], early, "tx bit changed early");
            check_line(mid[i], late, "tx bit changed late");
        end
        check_line(1'b0, mid[0], "tx start bit");
        data = mid[8:1];
        stop = mid[9];
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic idle_after_reset();
        wb_data_t     w;
        uart_status_t st;
        @(negedge clock);
        check_line(1'b1, tx, "tx after reset");
        read_status(st);
        check_status(make_status(0, 0, 0, 0), st, "status after reset");
        bus_read(2'd3, w);
        check_word('0, w, "read of address 3");
    endtask

    task automatic send_one_byte();
        uart_byte_t   data, got;
        logic         stop;
        int           start_cycle, ack_cycle;
        wb_data_t     w;
        uart_status_t st;
        data = rand_byte();
        fork
            watch_tx_frame(got, stop, start_cycle);
            begin
                bus_access(1'b1, reg_data, {24'h0, data}, w, ack_cycle);
                read_status(st);
                check_status(make_status(0, 0, 0, 1), st, "status during tx frame");
            end
        join
        check_byte(data, got, "tx frame data");
        check_line(1'b1, stop, "tx stop bit");
        read_status(st);
        check_status(make_status(0, 0, 0, 0), st, "status after tx frame");
    endtask

    task automatic receive_one_byte();
        uart_byte_t   data;
        wb_data_t     w;
        uart_status_t st;
        data = rand_byte();
        send_rx_frame(data, 1'b1);
        read_status(st);
        check_status(make_status(0, 0, 1, 0), st, "status after rx frame");
        bus_read(reg_data, w);
        check_byte(data, w[7:0], "rx data");
        read_status(st);
        check_status(make_status(0, 0, 0, 0), st, "status after data read");
    endtask

    task automatic receive_overrun();
        uart_byte_t   first, second;
        wb_data_t     w;
        uart_status_t st;
        first  = rand_byte();
        second = rand_byte();
        send_rx_frame(first, 1'b1);
        send_rx_frame(second, 1'b1);
        read_status(st);
        check_status(make_status(0, 1, 1, 0), st, "status after two frames");
        bus_read(reg_data, w);
        check_byte(second, w[7:0], "rx data after overrun");
        read_status(st);
        check_status(make_status(0, 0, 0, 0), st, "status after overrun cleared");
    endtask

    task automatic receive_bad_stop();
        uart_status_t st;
        send_rx_frame(rand_byte(), 1'b0);
        read_status(st);
        check_status(make_status(1, 0, 0, 0), st, "status after bad stop bit");
        read_status(st);
        check_status(make_status(0, 0, 0, 0), st, "status after frame error cleared");
    endtask

    task automatic write_back_pressure();
        uart_byte_t d1, d2, g1, g2;
        logic       s1, s2;
        int         start1, start2, ack1, ack2;
        wb_data_t   w;
        d1 = rand_byte();
        d2 = rand_byte();
        fork
            begin
                watch_tx_frame(g1, s1, start1);
                watch_tx_frame(g2, s2, start2);
            end
            begin
                bus_access(1'b1, reg_data, {24'h0, d1}, w, ack1);
                bus_access(1'b1, reg_data, {24'h0, d2}, w, ack2);
            end
        join
        if (ack2 <= start1 + 10 * clks_per_bit) begin
            failures++;
            $display("second write was acknowledged before the first frame ended");
        end
        check_byte(d1, g1, "first frame data");
        check_line(1'b1, s1, "first frame stop bit");
        check_byte(d2, g2, "second frame data");
        check_line(1'b1, s2, "second frame stop bit");
    endtask

    initial begin
        reset    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        wb_sel   <= '0;
        rx       <= 1'b1;  // line idles high
        repeat (10) @(posedge clock);
        reset <= 1'b1;

        idle_after_reset();
        send_one_byte();
        receive_one_byte();
        receive_overrun();
        receive_bad_stop();
        write_back_pressure();

        $display("%0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  uart_bus_pkg::wb_addr_t wb_adr,
    input  uart_bus_pkg::wb_data_t wb_dat_w,
    input  uart_bus_pkg::wb_sel_t  wb_sel,
    output uart_bus_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack,
    input  logic                   rx,
    output logic                   tx
);

    uart_chan_if chan ();

    uart_regs u_regs (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .chan     (chan.regs)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
        .clock (clock),
        .reset (reset),
        .chan  (chan.tx),
        .tx    (tx)
    );

    uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
        .clock (clock),
        .reset (reset),
        .rx    (rx),
        .chan  (chan.rx)
    );

endmodule

`default_nettype wire

//--- hw/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  uart_bus_pkg::wb_addr_t wb_adr,
    input  uart_bus_pkg::wb_data_t wb_dat_w,
    input  uart_bus_pkg::wb_sel_t  wb_sel,
    output uart_bus_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack,
    uart_chan_if.regs              chan
);
    import uart_bus_pkg::*;

    reg_addr_e    addr;
    logic         active;
    logic         is_data, is_status;
    logic         tx_write, tx_stall, tx_load;
    uart_byte_t   rx_byte;
    logic         rx_valid, rx_overrun, frame_error;
    uart_status_t status;

    // ************************************************************************
    // address decode and transfer qualifiers
    // ************************************************************************
    assign addr      = reg_addr_e'(wb_adr);
    assign active    = wb_cyc && wb_stb && !wb_ack;  // one ack per transfer
    assign is_data   = (addr == reg_data);
    assign is_status = (addr == reg_status);

    assign tx_write = active && wb_we && is_data && wb_sel[0];
    assign tx_stall = tx_write && chan.tx_busy;  // back-pressure
    assign tx_load  = tx_write && !chan.tx_busy;

    always_comb begin
        status.frame_error = frame_error;
        status.rx_overrun  = rx_overrun;
        status.rx_valid    = rx_valid;
        status.tx_busy     = chan.tx_busy;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wb_ack        <= 1'b0;
            chan.tx_start <= 1'b0;
            rx_valid      <= 1'b0;
            rx_overrun    <= 1'b0;
            frame_error   <= 1'b0;
        end else begin
            wb_ack        <= active && !tx_stall;
            chan.tx_start <= tx_load;

            // read side effects
            if (active && !wb_we && is_data)
                rx_valid <= 1'b0;
            if (active && !wb_we && is_status) begin
                rx_overrun  <= 1'b0;
                frame_error <= 1'b0;
            end

            // a new frame wins over a clear in the same cycle
            if (chan.rx_done) begin
                if (chan.rx_error) begin
                    frame_error <= 1'b1;
                end else begin
                    rx_valid <= 1'b1;
                    if (rx_valid) rx_overrun <= 1'b1;
                end
            end
        end
    end

    // ************************************************************************
    // payload registers
    // ************************************************************************
    always_ff @(posedge clock) begin
        if (tx_load)
            chan.tx_data <= wb_dat_w[7:0];
        if (chan.rx_done && !chan.rx_error)
            rx_byte <= chan.rx_data;  // always replaces the held byte
        if (active && !wb_we) begin
            case (addr)
                reg_data:   wb_dat_r <= wb_data_t'(rx_byte);
                reg_status: wb_dat_r <= wb_data_t'(status);
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    rx,
    uart_chan_if.rx chan
);
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    localparam int unsigned cnt_w = $clog2(clks_per_bit);
    localparam int unsigned bit_w = $clog2(data_bits);

    rx_state_e  state;
    logic       rx_meta, rx_sync, rx_prev;
    logic [cnt_w-1:0] clk_cnt;
    logic [bit_w-1:0] bit_cnt;
    uart_byte_t shift;
    logic       half_bit, full_bit;

    assign half_bit = (clk_cnt == cnt_w'(clks_per_bit / 2 - 1));
    assign full_bit = (clk_cnt == cnt_w'(clks_per_bit - 1));
    assign chan.rx_data = shift;  // stable until the next frame's data bits

    // two-flop synchronizer plus edge history, line idles high
    always_ff @(posedge clock) begin
        if (!reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ************************************************************************
    // receive sequencer, all samples taken at mid-bit
    // ************************************************************************
    always_ff @(posedge clock) begin
        if (!reset) begin
            state         <= rx_idle;
            clk_cnt       <= '0;
            bit_cnt       <= '0;
            chan.rx_done  <= 1'b0;
            chan.rx_error <= 1'b0;
        end else begin
            chan.rx_done <= 1'b0;
            clk_cnt      <= clk_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= rx_start_bit;  // falling edge
                end
                rx_start_bit: if (half_bit) begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    // glitch, not a start bit
                    state   <= rx_sync ? rx_idle : rx_data_bit;
                end
                rx_data_bit: if (full_bit) begin
                    clk_cnt <= '0;
                    if (bit_cnt == bit_w'(data_bits - 1))
                        state <= rx_stop_bit;
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                rx_stop_bit: if (full_bit) begin
                    state         <= rx_idle;
                    chan.rx_done  <= 1'b1;
                    chan.rx_error <= !rx_sync;  // stop bit must be high
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clock) begin
        if (state == rx_data_bit && full_bit)
            shift <= {rx_sync, shift[data_bits-1:1]};
    end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int unsigned clks_per_bit = uart_cfg_pkg::default_clks_per_bit
) (
    input  logic    clock,
    input  logic    reset,
    uart_chan_if.tx chan,
    output logic    tx
);
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    localparam int unsigned cnt_w = $clog2(clks_per_bit);
    localparam int unsigned bit_w = $clog2(data_bits);

    tx_state_e  state;
    logic [cnt_w-1:0] clk_cnt;
    logic [bit_w-1:0] bit_cnt;
    uart_byte_t shift;
    logic       bit_end;

    assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));
    assign chan.tx_busy = (state != tx_idle);

    // ************************************************************************
    // frame sequencer, tx is always a flop output
    // ************************************************************************
    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= tx_idle;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            clk_cnt <= (state == tx_idle || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                tx_idle: if (chan.tx_start) begin
                    state <= tx_start_bit;
                    tx    <= 1'b0;
                end
                tx_start_bit: if (bit_end) begin
                    state   <= tx_data_bit;
                    bit_cnt <= '0;
                    tx      <= shift[0];   // lsb first
                end
                tx_data_bit: if (bit_end) begin
                    if (bit_cnt == bit_w'(data_bits - 1)) begin
                        state <= tx_stop_bit;
                        tx    <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx      <= shift[0];
                    end
                end
                tx_stop_bit: if (bit_end) state <= tx_idle;
                default: state <= tx_idle;
            endcase
        end
    end

    // shift register
    always_ff @(posedge clock) begin
        if (state == tx_idle && chan.tx_start)
            shift <= chan.tx_data;
        else if (bit_end && (state == tx_start_bit || state == tx_data_bit))
            shift <= shift >> 1;
    end

endmodule

`default_nettype wire

//--- hw/uart_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_chan_if;
    import uart_bus_pkg::*;

    // transmit side
    uart_byte_t tx_data;
    logic       tx_start;   // one-cycle pulse, only while tx_busy low
    logic       tx_busy;

    // receive side, no back-pressure
    uart_byte_t rx_data;
    logic       rx_done;    // one-cycle pulse
    logic       rx_error;   // valid with rx_done

    modport regs (
        output tx_data, tx_start,
        input  tx_busy,
        input  rx_data, rx_done, rx_error
    );

    modport tx (
        input  tx_data, tx_start,
        output tx_busy
    );

    modport rx (
        output rx_data, rx_done, rx_error
    );

endinterface

`default_nettype wire

//--- hw/uart_bus_pkg.sv
`default_nettype none

package uart_bus_pkg;

    typedef logic [1:0]  wb_addr_t;  // word address
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // register map, 2 and 3 read as zero
    typedef enum logic [1:0] {
        reg_data   = 2'd0,
        reg_status = 2'd1
    } reg_addr_e;

    typedef logic [uart_cfg_pkg::data_bits-1:0] uart_byte_t;

    // low bits of a status read
    typedef struct packed {
        logic frame_error;
        logic rx_overrun;
        logic rx_valid;
        logic tx_busy;
    } uart_status_t;

endpackage

`default_nettype wire

//--- hw/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // 8N1 frame
    localparam int unsigned data_bits = 8;

    // short bit period keeps simulation runs quick
    localparam int unsigned default_clks_per_bit = 16;

    typedef enum logic [1:0] {
        tx_idle      = 2'd0,
        tx_start_bit = 2'd1,
        tx_data_bit  = 2'd2,
        tx_stop_bit  = 2'd3
    } tx_state_e;

    typedef enum logic [1:0] {
        rx_idle      = 2'd0,
        rx_start_bit = 2'd1,
        rx_data_bit  = 2'd2,
        rx_stop_bit  = 2'd3
    } rx_state_e;

endpackage

`default_nettype wire
